// ==== filelist.f ====
+incdir+common
common/dcache_pkg.sv
verilog/dpsram.sv
dcache/cache_way.sv
dcache/storebuffer.sv
dcache/dcache.sv
tests/tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_dcache \
    --Mdir obj_dir -o tb_dcache || { echo "build failed"; exit 1; }

out=$(./obj_dir/tb_dcache)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1

// ==== tests/tb_dcache.sv ====
`include "dcache_cfg.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int STIM_CYCLES = 1820;
    localparam int MAX_CYCLES  = 4000;
    localparam int SB_SIZE     = `DCACHE_SB_SIZE;

    logic         clk = 1'b0;
    logic         rst_n_i;
    logic         stall_i;
    logic         flush_i;
    logic         lsu_req_valid_i;
    logic         lsu_req_ready_o;
    lsu_req_t     lsu_req;
    logic         lsu_resp_valid_o;
    logic         lsu_resp_ready_i;
    lsu_resp_t    lsu_resp_o;
    logic         commit_req_valid_i;
    logic         commit_req_ready_o;
    commit_req_t  commit_req;
    commit_resp_t commit_resp_o;

    // reference model state
    logic         tag_v [`DCACHE_WAY_NUM][`DCACHE_SET_NUM];
    logic [21:0]  tag_m [`DCACHE_WAY_NUM][`DCACHE_SET_NUM];
    logic [31:0]  data_m [`DCACHE_WAY_NUM][`DCACHE_SET_NUM * `DCACHE_LINE_WORDS];
    sb_entry_t    sb_q [$];
    logic         m1_pending = 1'b0;
    lsu_req_t     m1_req;
    lsu_resp_t    m1_resp;
    logic         m1_way;
    logic         commit_expect = 1'b0;
    sb_entry_t    commit_entry;

    // handshakes seen before the coming edge
    logic         req_fire = 1'b0;
    logic         resp_fire = 1'b0;
    logic         commit_fire = 1'b0;

    int           value_errs = 0;
    int           protocol_errs = 0;
    int           checks = 0;
    int           cycle_cnt = 0;

    dcache uut (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .flush_i           (flush_i),
        .lsu_req_valid_i   (lsu_req_valid_i),
        .lsu_req_ready_o   (lsu_req_ready_o),
        .lsu_req_i         (lsu_req),
        .lsu_resp_valid_o  (lsu_resp_valid_o),
        .lsu_resp_ready_i  (lsu_resp_ready_i),
        .lsu_resp_o        (lsu_resp_o),
        .commit_req_valid_i(commit_req_valid_i),
        .commit_req_ready_o(commit_req_ready_o),
        .commit_req_i      (commit_req),
        .commit_resp_o     (commit_resp_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                   input logic [63:0] got_val);
        $display("** Error at time %0t: %s expected 0x%0h got 0x%0h",
                 $time, name, exp_val, got_val);
        value_errs++;
    endtask

    task automatic report_failure(input string msg);
        $display("Failure at time %0t: %s", $time, msg);
        protocol_errs++;
    endtask

    // 4 sets and 3 tags keep hits and forwarding frequent
    function automatic logic [31:0] rand_addr();
        logic [21:0] t;
        logic [5:0]  s;
        logic [1:0]  wd;
        t  = 22'($urandom % 3 + 1);
        s  = 6'($urandom % 4);
        wd = 2'($urandom % 4);
        return {t, s, wd, 2'b00};
    endfunction

    // refill into the way already holding the tag, so a tag sits in one way only
    function automatic logic pick_way(input logic [31:0] addr);
        logic w;
        w = 1'($urandom % 2);
        for (int i = 0; i < `DCACHE_WAY_NUM; i++) begin
            if (tag_v[i][addr[9:4]] && tag_m[i][addr[9:4]] == addr[31:10]) begin
                w = 1'(i);
            end
        end
        return w;
    endfunction

    function automatic void predict(input lsu_req_t req, output lsu_resp_t resp,
                                    output logic way);
        logic        thit;
        logic [31:0] cdata;
        logic [3:0]  fmask;
        logic [31:0] fdata;
        thit  = 1'b0;
        way   = 1'b0;
        cdata = '0;
        fmask = '0;
        fdata = '0;
        for (int w = 0; w < `DCACHE_WAY_NUM; w++) begin
            if (tag_v[w][req.addr[9:4]] && tag_m[w][req.addr[9:4]] == req.addr[31:10]) begin
                thit  = 1'b1;
                way   = 1'(w);
                cdata = data_m[w][req.addr[9:2]];
            end
        end
        // queue runs oldest to youngest
        foreach (sb_q[i]) begin
            for (int b = 0; b < 4; b++) begin
                if (sb_q[i].wstrb[b] && sb_q[i].addr[31:2] == req.addr[31:2]) begin
                    fmask[b]        = 1'b1;
                    fdata[8*b +: 8] = sb_q[i].wdata[8*b +: 8];
                end
            end
        end
        resp = '0;
        if (req.wstrb != 4'h0) begin
            resp.is_store = 1'b1;
            resp.hit      = thit;
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (fmask[b]) begin
                    resp.rdata[8*b +: 8] = fdata[8*b +: 8];
                end else if (thit) begin
                    resp.rdata[8*b +: 8] = cdata[8*b +: 8];
                end
            end
            resp.hit = &(fmask | {4{thit}} | ~req.rmask);
        end
    endfunction

    // phase 0 loads, 1 fills, 2 stores without commit, 3 everything, 4 flushes, 5 drain
    task automatic drive_inputs(input int phase);
        logic [31:0] a;
        lsu_resp_ready_i = (phase == 3 || phase == 4) ? ($urandom % 4 != 0) : 1'b1;
        stall_i = (phase == 3 || phase == 4) && ($urandom % 16 == 0);
        flush_i = (phase == 4) && ($urandom % 24 == 0);
        // a request stays on the bus until it is taken
        if (!lsu_req_valid_i || req_fire) begin
            lsu_req_valid_i = (phase < 5) && ($urandom % 4 != 0);
            lsu_req.addr    = rand_addr();
            lsu_req.wdata   = $urandom;
            if (phase >= 2 && phase < 5 && $urandom % 2 == 0) begin
                lsu_req.wstrb = ($urandom % 3 == 0) ? 4'hf : 4'($urandom % 15 + 1);
                lsu_req.rmask = 4'h0;
            end else begin
                lsu_req.wstrb = 4'h0;
                lsu_req.rmask = 4'($urandom % 15 + 1);
            end
        end
        a                = rand_addr();
        commit_req.addr  = a;
        commit_req.wdata = $urandom;
        commit_req.way   = pick_way(a);
        commit_req.op    = CACHE_OP_FILL;
        case (phase)
            0: commit_req_valid_i = 1'b0;
            1: commit_req_valid_i = ($urandom % 2 == 0);
            2: commit_req_valid_i = ($urandom % 4 == 0);
            5: begin
                commit_req_valid_i = 1'b1;
                commit_req.op      = CACHE_OP_STORE;
            end
            default: begin
                commit_req_valid_i = ($urandom % 2 == 0);
                commit_req.op = ($urandom % 2 == 0) ? CACHE_OP_STORE : CACHE_OP_FILL;
            end
        endcase
    endtask

    task automatic check_outputs();
        logic m1_store;
        logic exp_rvalid;
        logic exp_rready;
        logic exp_cready;
        m1_store   = m1_pending && (m1_req.wstrb != 4'h0);
        exp_rvalid = m1_pending && !stall_i && !flush_i && (!m1_store || sb_q.size() < SB_SIZE);
        resp_fire  = exp_rvalid && lsu_resp_ready_i;
        exp_rready = !stall_i && !flush_i && (!m1_pending || resp_fire)
                     && (lsu_req.wstrb == 4'h0 || sb_q.size() + int'(m1_store) < SB_SIZE);
        exp_cready = (commit_req.op == CACHE_OP_FILL) || (sb_q.size() != 0);
        req_fire    = lsu_req_valid_i && exp_rready;
        commit_fire = commit_req_valid_i && exp_cready;
        checks += 4;
        if (lsu_req_ready_o !== exp_rready) begin
            report_mismatch("lsu_req_ready_o", 64'(exp_rready), 64'(lsu_req_ready_o));
        end
        if (commit_req_ready_o !== exp_cready) begin
            report_mismatch("commit_req_ready_o", 64'(exp_cready), 64'(commit_req_ready_o));
        end
        if (lsu_resp_valid_o === 1'b1 && !m1_pending) begin
            report_failure("response valid with no request in flight");
        end else if (lsu_resp_valid_o !== exp_rvalid) begin
            report_mismatch("lsu_resp_valid_o", 64'(exp_rvalid), 64'(lsu_resp_valid_o));
        end else if (exp_rvalid) begin
            // checked every valid cycle, so a held response must not move
            if (lsu_resp_o.rdata !== m1_resp.rdata) begin
                report_mismatch("lsu_resp_o.rdata", 64'(m1_resp.rdata), 64'(lsu_resp_o.rdata));
            end
            if (lsu_resp_o.hit !== m1_resp.hit) begin
                report_mismatch("lsu_resp_o.hit", 64'(m1_resp.hit), 64'(lsu_resp_o.hit));
            end
            if (lsu_resp_o.is_store !== m1_resp.is_store) begin
                report_mismatch("lsu_resp_o.is_store", 64'(m1_resp.is_store),
                                64'(lsu_resp_o.is_store));
            end
        end
        if (commit_resp_o.valid === 1'b1 && !commit_expect) begin
            report_failure("commit response pulse with no store retired");
        end else if (commit_resp_o.valid !== commit_expect) begin
            report_mismatch("commit_resp_o.valid", 64'(commit_expect), 64'(commit_resp_o.valid));
        end else if (commit_expect) begin
            if (commit_resp_o.entry.valid !== commit_entry.valid) begin
                report_mismatch("commit_resp_o.entry.valid", 64'(commit_entry.valid),
                                64'(commit_resp_o.entry.valid));
            end
            if (commit_resp_o.entry.addr !== commit_entry.addr) begin
                report_mismatch("commit_resp_o.entry.addr", 64'(commit_entry.addr),
                                64'(commit_resp_o.entry.addr));
            end
            if (commit_resp_o.entry.wdata !== commit_entry.wdata) begin
                report_mismatch("commit_resp_o.entry.wdata", 64'(commit_entry.wdata),
                                64'(commit_resp_o.entry.wdata));
            end
            if (commit_resp_o.entry.wstrb !== commit_entry.wstrb) begin
                report_mismatch("commit_resp_o.entry.wstrb", 64'(commit_entry.wstrb),
                                64'(commit_resp_o.entry.wstrb));
            end
            if (commit_resp_o.entry.hit !== commit_entry.hit) begin
                report_mismatch("commit_resp_o.entry.hit", 64'(commit_entry.hit),
                                64'(commit_resp_o.entry.hit));
            end else if (commit_entry.hit && commit_resp_o.entry.way !== commit_entry.way) begin
                report_mismatch("commit_resp_o.entry.way", 64'(commit_entry.way),
                                64'(commit_resp_o.entry.way));
            end
        end
    endtask

    // effects of one edge, in the order the cache sees them
    task automatic update_model();
        sb_entry_t e;
        lsu_resp_t r;
        logic      w;
        commit_expect = 1'b0;
        if (commit_fire) begin
            if (commit_req.op == CACHE_OP_FILL) begin
                tag_v[commit_req.way][commit_req.addr[9:4]]  = 1'b1;
                tag_m[commit_req.way][commit_req.addr[9:4]]  = commit_req.addr[31:10];
                data_m[commit_req.way][commit_req.addr[9:2]] = commit_req.wdata;
            end else begin
                e = sb_q.pop_front();
                for (int b = 0; b < 4; b++) begin
                    if (e.hit && e.wstrb[b]) begin
                        data_m[e.way][e.addr[9:2]][8*b +: 8] = e.wdata[8*b +: 8];
                    end
                end
                commit_expect = 1'b1;
                commit_entry  = e;
            end
        end
        if (resp_fire) begin
            if (m1_req.wstrb != 4'h0) begin
                e       = '0;
                e.addr  = m1_req.addr;
                e.wdata = m1_req.wdata;
                e.wstrb = m1_req.wstrb;
                e.hit   = m1_resp.hit;
                e.way   = m1_way;
                e.valid = 1'b1;
                sb_q.push_back(e);
            end
            m1_pending = 1'b0;
        end
        if (flush_i) begin
            m1_pending = 1'b0;
            sb_q.delete();
        end
        if (req_fire) begin
            predict(lsu_req, r, w);
            m1_req     = lsu_req;
            m1_resp    = r;
            m1_way     = w;
            m1_pending = 1'b1;
        end
    endtask

    task automatic run_cycle(input int phase);
        drive_inputs(phase);
        @(negedge clk);
        check_outputs();
        @(posedge clk);
        update_model();
        #1;
    endtask

    function automatic int phase_of(input int c);
        if (c < 40) return 0;
        if (c < 240) return 1;
        if (c < 320) return 2;
        if (c < 1320) return 3;
        return 4;
    endfunction

    initial begin
        void'($urandom(32'h4f637d62));
        for (int w = 0; w < `DCACHE_WAY_NUM; w++) begin
            for (int s = 0; s < `DCACHE_SET_NUM; s++) begin
                tag_v[w][s] = 1'b0;
                tag_m[w][s] = '0;
            end
            for (int i = 0; i < `DCACHE_SET_NUM * `DCACHE_LINE_WORDS; i++) begin
                data_m[w][i] = '0;
            end
        end
        rst_n_i            = 1'b0;
        stall_i            = 1'b0;
        flush_i            = 1'b0;
        lsu_req_valid_i    = 1'b0;
        lsu_req            = '0;
        lsu_resp_ready_i   = 1'b1;
        commit_req_valid_i = 1'b0;
        commit_req         = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        for (int c = 0; c < STIM_CYCLES; c++) begin
            run_cycle(phase_of(c));
        end
        // drain the pipeline and the store buffer
        while (lsu_req_valid_i || m1_pending || sb_q.size() != 0 || commit_expect) begin
            run_cycle(5);
        end
        $display("checks: %0d, value errors: %0d, protocol errors: %0d",
                 checks, value_errs, protocol_errs);
        if (value_errs == 0 && protocol_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== dcache/dcache.sv ====
`include "dcache_cfg.svh"

module dcache (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     stall_i,
    input  logic                     flush_i,
    input  logic                     lsu_req_valid_i,
    output logic                     lsu_req_ready_o,
    input  dcache_pkg::lsu_req_t     lsu_req_i,
    output logic                     lsu_resp_valid_o,
    input  logic                     lsu_resp_ready_i,
    output dcache_pkg::lsu_resp_t    lsu_resp_o,
    input  logic                     commit_req_valid_i,
    output logic                     commit_req_ready_o,
    input  dcache_pkg::commit_req_t  commit_req_i,
    output dcache_pkg::commit_resp_t commit_resp_o
);
    import dcache_pkg::*;

    localparam int unsigned SB_CNT_W = $clog2(`DCACHE_SB_SIZE + 1);

    logic                                req_fire;
    logic                                resp_fire;
    logic                                store_ok;
    logic                                m1_store;
    logic                                m1_valid_q;
    lsu_req_t                            m1_req_q;
    logic [SB_CNT_W-1:0]                 sb_used;
    cache_tag_t                          way_tag [`DCACHE_WAY_NUM];
    logic [31:0]                         way_data [`DCACHE_WAY_NUM];
    logic                                fill_fire;
    logic                                store_fire;
    logic [31:0]                         wr_addr;
    logic [31:0]                         wr_data;
    cache_tag_t                          wr_tag;
    logic                                commit_valid_q;
    sb_entry_t                           commit_entry_q;
    logic                                sb_push_valid;
    logic                                sb_push_ready;
    logic                                sb_pop_valid;
    logic                                sb_pop_ready;
    sb_entry_t                           sb_push_entry;
    sb_entry_t                           sb_pop_entry;
    sb_entry_t [`DCACHE_SB_SIZE-1:0]     sb_entries;
    logic                                tag_hit;
    logic [WAY_W-1:0]                    hit_way;
    logic [31:0]                         hit_data;
    logic [3:0]                          fwd_mask;
    logic [31:0]                         fwd_data;
    lsu_resp_t                           resp_comb;
    logic                                hold_q;
    lsu_resp_t                           hold_resp_q;
    logic [WAY_W-1:0]                    hold_way_q;

    // stage 0 handshake
    assign m1_store = m1_valid_q & (|m1_req_q.wstrb);

    always_comb begin
        sb_used = '0;
        for (int e = 0; e < `DCACHE_SB_SIZE; e++) begin
            sb_used = sb_used + SB_CNT_W'(sb_entries[e].valid);
        end
    end

    // a store in M1 will need a slot too
    assign store_ok = ~(|lsu_req_i.wstrb)
                    | ((sb_used + SB_CNT_W'(m1_store)) < SB_CNT_W'(`DCACHE_SB_SIZE));

    assign lsu_req_ready_o  = ~stall_i & ~flush_i & (~m1_valid_q | resp_fire) & store_ok;
    assign req_fire         = lsu_req_valid_i & lsu_req_ready_o;
    assign lsu_resp_valid_o = m1_valid_q & ~stall_i & ~flush_i & (~m1_store | sb_push_ready);
    assign resp_fire        = lsu_resp_valid_o & lsu_resp_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            m1_valid_q <= 1'b0;
        end else if (flush_i) begin
            m1_valid_q <= 1'b0;
        end else if (req_fire) begin
            m1_valid_q <= 1'b1;
        end else if (resp_fire) begin
            m1_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            m1_req_q <= lsu_req_i;
        end
    end

    // port 0 reads the incoming request, port 1 takes the commit write
    for (genvar i = 0; i < `DCACHE_WAY_NUM; i++) begin : g_way
        logic       tag_en;
        logic [3:0] data_be;

        assign tag_en = fill_fire & (commit_req_i.way == WAY_W'(i));

        always_comb begin
            data_be = '0;
            if (tag_en) begin
                data_be = 4'hf;
            end else if (store_fire & sb_pop_entry.hit & (sb_pop_entry.way == WAY_W'(i))) begin
                data_be = sb_pop_entry.wstrb;
            end
        end

        cache_way u_way (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .rd_en_i     (req_fire),
            .rd_addr_i   (lsu_req_i.addr),
            .wr_tag_en_i (tag_en),
            .wr_data_be_i(data_be),
            .wr_addr_i   (wr_addr),
            .wr_tag_i    (wr_tag),
            .wr_data_i   (wr_data),
            .tag_o       (way_tag[i]),
            .data_o      (way_data[i])
        );
    end

    // M1 tag compare
    always_comb begin
        tag_hit  = 1'b0;
        hit_way  = '0;
        hit_data = '0;
        for (int i = 0; i < `DCACHE_WAY_NUM; i++) begin
            if (way_tag[i].valid && (way_tag[i].tag == addr_tag(m1_req_q.addr))) begin
                tag_hit  = 1'b1;
                hit_way  = WAY_W'(i);
                hit_data = way_data[i];
            end
        end
    end

    // later entries are younger and win per byte
    always_comb begin
        fwd_mask = '0;
        fwd_data = '0;
        for (int e = 0; e < `DCACHE_SB_SIZE; e++) begin
            for (int b = 0; b < 4; b++) begin
                if (sb_entries[e].valid && sb_entries[e].wstrb[b]
                    && (sb_entries[e].addr[31:2] == m1_req_q.addr[31:2])) begin
                    fwd_mask[b]        = 1'b1;
                    fwd_data[8*b +: 8] = sb_entries[e].wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        resp_comb = '0;
        if (|m1_req_q.wstrb) begin
            resp_comb.is_store = 1'b1;
            resp_comb.hit      = tag_hit;
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (fwd_mask[b]) begin
                    resp_comb.rdata[8*b +: 8] = fwd_data[8*b +: 8];
                end else if (tag_hit) begin
                    resp_comb.rdata[8*b +: 8] = hit_data[8*b +: 8];
                end
            end
            // every needed byte must come from somewhere
            resp_comb.hit = &(fwd_mask | {4{tag_hit}} | ~m1_req_q.rmask);
        end
    end

    // freeze the response after its first M1 cycle until it transfers
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hold_q <= 1'b0;
        end else if (flush_i) begin
            hold_q <= 1'b0;
        end else begin
            hold_q <= m1_valid_q & ~resp_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_q) begin
            hold_resp_q <= resp_comb;
            hold_way_q  <= hit_way;
        end
    end

    assign lsu_resp_o = hold_q ? hold_resp_q : resp_comb;

    // store enters the buffer as its response transfers
    assign sb_push_valid       = resp_fire & m1_store;
    assign sb_push_entry.addr  = m1_req_q.addr;
    assign sb_push_entry.wdata = m1_req_q.wdata;
    assign sb_push_entry.wstrb = m1_req_q.wstrb;
    assign sb_push_entry.hit   = lsu_resp_o.hit;
    assign sb_push_entry.way   = hold_q ? hold_way_q : hit_way;
    assign sb_push_entry.valid = 1'b1;

    storebuffer #(
        .SB_SIZE(`DCACHE_SB_SIZE)
    ) u_sb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .push_valid_i(sb_push_valid),
        .push_ready_o(sb_push_ready),
        .push_entry_i(sb_push_entry),
        .pop_valid_o (sb_pop_valid),
        .pop_ready_i (sb_pop_ready),
        .pop_entry_o (sb_pop_entry),
        .entries_o   (sb_entries)
    );

    // commit decode
    assign fill_fire          = commit_req_valid_i & (commit_req_i.op == CACHE_OP_FILL);
    assign sb_pop_ready       = commit_req_valid_i & (commit_req_i.op == CACHE_OP_STORE);
    assign store_fire         = sb_pop_ready & sb_pop_valid;
    assign commit_req_ready_o = (commit_req_i.op == CACHE_OP_FILL) | sb_pop_valid;

    assign wr_addr = fill_fire ? commit_req_i.addr : sb_pop_entry.addr;
    assign wr_data = fill_fire ? commit_req_i.wdata : sb_pop_entry.wdata;
    assign wr_tag  = '{tag: addr_tag(commit_req_i.addr), valid: 1'b1};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_valid_q <= 1'b0;
        end else begin
            commit_valid_q <= store_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (store_fire) begin
            commit_entry_q <= sb_pop_entry;
        end
    end

    assign commit_resp_o.valid = commit_valid_q;
    assign commit_resp_o.entry = commit_entry_q;

endmodule

// ==== dcache/storebuffer.sv ====
`include "dcache_cfg.svh"

module storebuffer #(
    parameter int unsigned SB_SIZE = `DCACHE_SB_SIZE
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  logic                                push_valid_i,
    output logic                                push_ready_o,
    input  dcache_pkg::sb_entry_t               push_entry_i,
    output logic                                pop_valid_o,
    input  logic                                pop_ready_i,
    output dcache_pkg::sb_entry_t               pop_entry_o,
    output dcache_pkg::sb_entry_t [SB_SIZE-1:0] entries_o
);
    import dcache_pkg::*;

    localparam int unsigned PTR_W = $clog2(SB_SIZE);

    sb_entry_t        mem [SB_SIZE];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;
    logic             push;
    logic             pop;

    assign push_ready_o = (count_q < SB_SIZE);
    assign pop_valid_o  = (count_q != '0);
    assign push         = push_valid_i & push_ready_o;
    assign pop          = pop_valid_o & pop_ready_i;

    // oldest first; valid marks the slots that hold a store
    always_comb begin
        logic [PTR_W-1:0] idx;
        for (int k = 0; k < SB_SIZE; k++) begin
            idx = head_q + PTR_W'(k);
            entries_o[k]       = mem[idx];
            entries_o[k].valid = (k < count_q);
        end
    end

    assign pop_entry_o = entries_o[0];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail_q] <= push_entry_i;
        end
    end

    // pointers wrap on their own width
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

endmodule

// ==== dcache/cache_way.sv ====
`include "dcache_cfg.svh"

module cache_way (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   rd_en_i,
    input  logic [31:0]            rd_addr_i,
    input  logic                   wr_tag_en_i,
    input  logic [3:0]             wr_data_be_i,
    input  logic [31:0]            wr_addr_i,
    input  dcache_pkg::cache_tag_t wr_tag_i,
    input  logic [31:0]            wr_data_i,
    output dcache_pkg::cache_tag_t tag_o,
    output logic [31:0]            data_o
);
    import dcache_pkg::*;

    localparam int unsigned DATA_ADDR_W = INDEX_W + WORD_OFF_W;

    logic [INDEX_W-1:0]     rd_index;
    logic [INDEX_W-1:0]     wr_index;
    logic [DATA_ADDR_W-1:0] rd_word;
    logic [DATA_ADDR_W-1:0] wr_word;
    logic                   tag_conflict;
    logic                   tag_conflict_q;
    logic                   data_conflict;
    logic                   data_conflict_q;
    cache_tag_t             tag_rd0;
    cache_tag_t             tag_rd1;
    logic [31:0]            data_rd0;
    logic [31:0]            data_rd1;

    assign rd_index = addr_index(rd_addr_i);
    assign wr_index = addr_index(wr_addr_i);
    assign rd_word  = addr_word(rd_addr_i);
    assign wr_word  = addr_word(wr_addr_i);

    // a read hitting the word being written takes the port 1 result
    assign tag_conflict  = rd_en_i & wr_tag_en_i & (rd_index == wr_index);
    assign data_conflict = rd_en_i & (|wr_data_be_i) & (rd_word == wr_word);

    // select only moves with a read, like the port 0 output
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tag_conflict_q  <= 1'b0;
            data_conflict_q <= 1'b0;
        end else if (rd_en_i) begin
            tag_conflict_q  <= tag_conflict;
            data_conflict_q <= data_conflict;
        end
    end

    assign tag_o  = tag_conflict_q ? tag_rd1 : tag_rd0;
    assign data_o = data_conflict_q ? data_rd1 : data_rd0;

    dpsram #(
        .DATA_WIDTH($bits(cache_tag_t)),
        .DATA_DEPTH(`DCACHE_SET_NUM),
        .BYTE_SIZE ($bits(cache_tag_t))
    ) u_tag_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .addr0_i (rd_index),
        .en0_i   (rd_en_i & ~tag_conflict),
        .rdata0_o(tag_rd0),
        .addr1_i (wr_index),
        .we1_i   (wr_tag_en_i),
        .wdata1_i(wr_tag_i),
        .rdata1_o(tag_rd1)
    );

    dpsram #(
        .DATA_WIDTH(32),
        .DATA_DEPTH(`DCACHE_SET_NUM * `DCACHE_LINE_WORDS),
        .BYTE_SIZE (8)
    ) u_data_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .addr0_i (rd_word),
        .en0_i   (rd_en_i & ~data_conflict),
        .rdata0_o(data_rd0),
        .addr1_i (wr_word),
        .we1_i   (wr_data_be_i),
        .wdata1_i(wr_data_i),
        .rdata1_o(data_rd1)
    );

endmodule

// ==== verilog/dpsram.sv ====
module dpsram #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned DATA_DEPTH = 256,
    parameter int unsigned BYTE_SIZE  = 8
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic [$clog2(DATA_DEPTH)-1:0]       addr0_i,
    input  logic                                en0_i,
    output logic [DATA_WIDTH-1:0]               rdata0_o,
    input  logic [$clog2(DATA_DEPTH)-1:0]       addr1_i,
    input  logic [DATA_WIDTH/BYTE_SIZE-1:0]     we1_i,
    input  logic [DATA_WIDTH-1:0]               wdata1_i,
    output logic [DATA_WIDTH-1:0]               rdata1_o
);
    localparam int unsigned BYTE_NUM = DATA_WIDTH / BYTE_SIZE;

    logic [DATA_WIDTH-1:0] mem [DATA_DEPTH];
    logic [DATA_WIDTH-1:0] wr_word;

    // port 1 word after the byte enables are applied
    always_comb begin
        wr_word = mem[addr1_i];
        for (int b = 0; b < BYTE_NUM; b++) begin
            if (we1_i[b]) begin
                wr_word[b*BYTE_SIZE +: BYTE_SIZE] = wdata1_i[b*BYTE_SIZE +: BYTE_SIZE];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DATA_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (|we1_i) begin
            mem[addr1_i] <= wr_word;
        end
    end

    // port 0 keeps its last word while disabled
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata0_o <= '0;
        end else if (en0_i) begin
            rdata0_o <= mem[addr0_i];
        end
    end

    // write-first, so a write shows up here the next cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata1_o <= '0;
        end else begin
            rdata1_o <= wr_word;
        end
    end

endmodule

// ==== common/dcache_pkg.sv ====
`include "dcache_cfg.svh"

package dcache_pkg;

    // address split: word offset, set index, tag
    localparam int unsigned WORD_OFF_LO = 2;
    localparam int unsigned WORD_OFF_W  = $clog2(`DCACHE_LINE_WORDS);
    localparam int unsigned INDEX_LO    = WORD_OFF_LO + WORD_OFF_W;
    localparam int unsigned INDEX_W     = $clog2(`DCACHE_SET_NUM);
    localparam int unsigned TAG_LO      = INDEX_LO + INDEX_W;
    localparam int unsigned TAG_W       = 32 - TAG_LO;
    localparam int unsigned WAY_W       = $clog2(`DCACHE_WAY_NUM);

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } cache_tag_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        // nonzero marks a store
        logic [3:0]  wstrb;
        logic [3:0]  rmask;
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        hit;
        logic        is_store;
    } lsu_resp_t;

    typedef struct packed {
        logic [31:0]      addr;
        logic [31:0]      wdata;
        logic [3:0]       wstrb;
        logic             hit;
        logic [WAY_W-1:0] way;
        logic             valid;
    } sb_entry_t;

    typedef enum logic {
        CACHE_OP_FILL  = 1'b0,
        CACHE_OP_STORE = 1'b1
    } cache_op_e;

    typedef struct packed {
        cache_op_e        op;
        logic [31:0]      addr;
        logic [WAY_W-1:0] way;
        logic [31:0]      wdata;
    } commit_req_t;

    typedef struct packed {
        logic      valid;
        sb_entry_t entry;
    } commit_resp_t;

    function automatic logic [INDEX_W-1:0] addr_index(input logic [31:0] addr);
        return addr[INDEX_LO +: INDEX_W];
    endfunction

    // index and word offset together address one data word
    function automatic logic [INDEX_W+WORD_OFF_W-1:0] addr_word(input logic [31:0] addr);
        return addr[WORD_OFF_LO +: INDEX_W + WORD_OFF_W];
    endfunction

    function automatic logic [TAG_W-1:0] addr_tag(input logic [31:0] addr);
        return addr[TAG_LO +: TAG_W];
    endfunction

endpackage

// ==== common/dcache_cfg.svh ====
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// cache geometry
`define DCACHE_WAY_NUM    2
`define DCACHE_SET_NUM    64
`define DCACHE_LINE_WORDS 4

// pending stores waiting for commit, power of two
`define DCACHE_SB_SIZE    4

`endif
